// File: hdl/decode_pkg.sv
package decode_pkg;

   // Data width, also the serial pass length and immediate width
   localparam int XLEN = 32;
   localparam int CNT_W = $clog2(XLEN);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(XLEN - 1);

   // Major opcodes, instruction bits 6:2
   localparam logic [4:0] OP_LOAD   = 5'b00000;
   localparam logic [4:0] OP_STORE  = 5'b01000;
   localparam logic [4:0] OP_OPIMM  = 5'b00100;
   localparam logic [4:0] OP_OP     = 5'b01100;
   localparam logic [4:0] OP_BRANCH = 5'b11000;
   localparam logic [4:0] OP_JAL    = 5'b11011;
   localparam logic [4:0] OP_JALR   = 5'b11001;
   localparam logic [4:0] OP_LUI    = 5'b01101;
   localparam logic [4:0] OP_AUIPC  = 5'b00101;
   localparam logic [4:0] OP_SYSTEM = 5'b11100;

   typedef enum logic [1:0] {
      ALU_RESULT_ADD  = 2'd0,
      ALU_RESULT_SR   = 2'd1,
      ALU_RESULT_LT   = 2'd2,
      ALU_RESULT_BOOL = 2'd3
   } alu_rd_sel_e;

   // Only the CSRs that live in the register file
   typedef enum logic [1:0] {
      CSR_MSCRATCH = 2'd0,
      CSR_MEPC     = 2'd2,
      CSR_MTVAL    = 2'd3,
      CSR_MTVEC    = 2'd1
   } csr_addr_e;

   typedef struct packed {
      logic branch_op;
      logic jal_or_jalr;
      logic jalr;
      logic utype;
      logic pc_rel;
      logic mret;
      logic e_op;
      logic ebreak;
   } flow_ctrl_t;

   typedef struct packed {
      logic        sub;
      logic [1:0]  bool_op;
      logic        cmp_eq;
      logic        cmp_uns;
      logic        sh_signed;
      logic        sh_right;
      alu_rd_sel_e rd_sel;
      logic        shift_op;
      logic        slt_op;
      logic        op_b_source;
      logic        rd_alu_en;
   } alu_ctrl_t;

   typedef struct packed {
      logic mem_op;
      logic cmd;
      logic is_signed;
      logic word;
      logic half;
      logic rd_mem_en;
   } mem_ctrl_t;

   typedef struct packed {
      logic       rd_en;
      logic [4:0] rd_addr;
      logic [4:0] rs1_addr;
      logic [4:0] rs2_addr;
   } rf_ctrl_t;

   typedef struct packed {
      logic       en;
      csr_addr_e  addr;
      logic       mstatus_en;
      logic       mie_en;
      logic       mcause_en;
      logic [1:0] source;
      logic       d_sel;
      logic       rd_csr_en;
   } csr_ctrl_t;

endpackage

// File: hdl/count_sequencer.sv
`timescale 1ns/1ps

module count_sequencer
   import decode_pkg::*;
(
   input  logic clk,
   input  logic i_rst,
   input  logic i_start,
   output logic o_cnt_en,
   output logic o_cnt_last,
   output logic o_done
);

   logic [CNT_W-1:0] cnt;
   logic             active;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         cnt    <= '0;
         active <= 1'b0;
         o_done <= 1'b0;
      end else begin
         o_done <= 1'b0;
         if (active) begin
            cnt <= cnt + 1'b1;
            // Final bit of the pass
            if (cnt == CNT_LAST) begin
               active <= 1'b0;
               o_done <= 1'b1;
            end
         end else if (i_start) begin
            active <= 1'b1;
            cnt    <= '0;
         end
      end
   end

   assign o_cnt_en   = active;
   assign o_cnt_last = active & (cnt == CNT_LAST);

endmodule

// File: hdl/serial_compare.sv
`timescale 1ns/1ps

module serial_compare
   import decode_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst,
   input  logic      i_cnt_en,
   input  logic      i_cnt_last,
   input  logic      i_rs1_bit,
   input  logic      i_rs2_bit,
   input  alu_ctrl_t i_alu,
   output logic      o_cmp
);

   logic pass_q;
   logic eq_q;
   logic lt_q;
   logic first;
   logic differs;
   logic eq_next;
   logic lt_next;

   // High only on bit 0 of a pass
   assign first   = i_cnt_en & ~pass_q;
   assign differs = i_rs1_bit ^ i_rs2_bit;

   always_comb begin
      eq_next = ~differs & (first | eq_q);
      if (differs) begin
         // Sign bit flips the order for signed compares
         if (i_cnt_last && !i_alu.cmp_uns) begin
            lt_next = i_rs1_bit;
         end else begin
            lt_next = i_rs2_bit;
         end
      end else begin
         lt_next = first ? 1'b0 : lt_q;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         pass_q <= 1'b0;
         eq_q   <= 1'b0;
         lt_q   <= 1'b0;
      end else begin
         pass_q <= i_cnt_en & ~i_cnt_last;
         if (i_cnt_en) begin
            eq_q <= eq_next;
            lt_q <= lt_next;
         end
      end
   end

   assign o_cmp = i_alu.cmp_eq ? eq_q : lt_q;

endmodule

// File: hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
   import decode_pkg::*;
(
   input  logic            clk,
   input  logic            i_wb_en,
   input  logic            i_cnt_en,
   input  logic            i_cmp,
   input  logic [XLEN-1:0] i_wb_rdt,
   output flow_ctrl_t      o_flow,
   output alu_ctrl_t       o_alu,
   output mem_ctrl_t       o_mem,
   output rf_ctrl_t        o_rf,
   output csr_ctrl_t       o_csr,
   output logic            o_take_branch,
   output logic            o_imm
);

   logic [4:0]      opcode;
   logic [2:0]      funct3;
   logic            op20;
   logic            op21;
   logic            op22;
   logic            op26;
   logic            op30;
   logic [4:0]      rd_addr;
   logic [4:0]      rs1_addr;
   logic [4:0]      rs2_addr;
   logic [XLEN-1:0] imm_q;
   logic [XLEN-1:0] imm_word;
   alu_rd_sel_e     rd_sel_q;
   logic            op_or_opimm;
   logic            csr_op;
   logic            csr_valid;

   // Immediate by format of the incoming word
   always_comb begin
      case (i_wb_rdt[6:2])
         OP_STORE:
            imm_word = {{20{i_wb_rdt[31]}}, i_wb_rdt[31:25], i_wb_rdt[11:7]};
         OP_BRANCH:
            imm_word = {{20{i_wb_rdt[31]}}, i_wb_rdt[7], i_wb_rdt[30:25],
                        i_wb_rdt[11:8], 1'b0};
         OP_LUI, OP_AUIPC:
            imm_word = {i_wb_rdt[31:12], 12'd0};
         OP_JAL:
            imm_word = {{12{i_wb_rdt[31]}}, i_wb_rdt[19:12], i_wb_rdt[20],
                        i_wb_rdt[30:21], 1'b0};
         default:
            imm_word = {{20{i_wb_rdt[31]}}, i_wb_rdt[31:20]};
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_wb_en) begin
         opcode   <= i_wb_rdt[6:2];
         funct3   <= i_wb_rdt[14:12];
         op20     <= i_wb_rdt[20];
         op21     <= i_wb_rdt[21];
         op22     <= i_wb_rdt[22];
         op26     <= i_wb_rdt[26];
         op30     <= i_wb_rdt[30];
         rd_addr  <= i_wb_rdt[11:7];
         rs1_addr <= i_wb_rdt[19:15];
         rs2_addr <= i_wb_rdt[24:20];
         imm_q    <= imm_word;
      end else if (i_cnt_en) begin
         // LSB out first, word is back in place after a full pass
         imm_q <= {imm_q[0], imm_q[XLEN-1:1]};
      end
   end

   // One cycle behind the latched funct3
   always_ff @(posedge clk) begin
      casez (funct3)
         3'b000:  rd_sel_q <= ALU_RESULT_ADD;
         3'b001:  rd_sel_q <= ALU_RESULT_SR;
         3'b01?:  rd_sel_q <= ALU_RESULT_LT;
         3'b100:  rd_sel_q <= ALU_RESULT_BOOL;
         3'b101:  rd_sel_q <= ALU_RESULT_SR;
         default: rd_sel_q <= ALU_RESULT_BOOL;
      endcase
   end

   assign op_or_opimm = ~opcode[4] & opcode[2] & ~opcode[0];

   always_comb begin
      o_flow.branch_op   = opcode[4] & ~opcode[2];
      o_flow.jal_or_jalr = opcode[4] & opcode[0];
      o_flow.jalr        = opcode[4] & (opcode[1:0] == 2'b01);
      o_flow.utype       = ~opcode[4] & opcode[2] & opcode[0];
      // jal, branches and auipc
      o_flow.pc_rel      = (opcode[2:0] == 3'b000) | (opcode[1:0] == 2'b11) |
                           (opcode[4:3] == 2'b00);
      o_flow.mret        = opcode[4] & opcode[2] & op21 & ~(|funct3);
      o_flow.e_op        = opcode[4] & opcode[2] & ~op21 & ~(|funct3);
      o_flow.ebreak      = op20;
   end

   always_comb begin
      o_alu.sub         = opcode[3] & op30;
      o_alu.bool_op     = funct3[1:0];
      o_alu.cmp_eq      = (funct3[2:1] == 2'b00);
      o_alu.cmp_uns     = (funct3[0] & funct3[1]) | (funct3[1] & funct3[2]);
      o_alu.sh_signed   = op30;
      o_alu.sh_right    = funct3[2];
      o_alu.rd_sel      = rd_sel_q;
      o_alu.shift_op    = op_or_opimm & (funct3[1:0] == 2'b01);
      o_alu.slt_op      = op_or_opimm & (funct3[2:1] == 2'b01);
      // rs2 for OP and branches, immediate otherwise
      o_alu.op_b_source = opcode[3];
      o_alu.rd_alu_en   = ~opcode[0] & opcode[2] & ~opcode[4];
   end

   always_comb begin
      o_mem.mem_op    = ~opcode[4] & ~opcode[2] & ~opcode[0];
      o_mem.cmd       = opcode[3];
      o_mem.is_signed = ~funct3[2];
      o_mem.word      = funct3[1];
      o_mem.half      = funct3[0];
      o_mem.rd_mem_en = ~opcode[2] & ~opcode[4];
   end

   always_comb begin
      o_rf.rd_en    = opcode[2] | (opcode[4] & opcode[0]) |
                      (~opcode[3] & ~opcode[0]);
      o_rf.rd_addr  = rd_addr;
      o_rf.rs1_addr = rs1_addr;
      o_rf.rs2_addr = rs2_addr;
   end

   // System ops other than ecall, ebreak and mret
   assign csr_op    = opcode[4] & opcode[2] & (|funct3);
   // mtvec, mscratch, mepc and mtval are stored in the register file
   assign csr_valid = op20 | (op26 & ~op22 & ~op21);

   always_comb begin
      o_csr.en         = csr_op & csr_valid;
      o_csr.mstatus_en = csr_op & ~op26 & ~op22;
      o_csr.mie_en     = csr_op & ~op26 & op22 & ~op20;
      o_csr.mcause_en  = csr_op & op21 & ~op20;
      o_csr.source     = funct3[1:0];
      o_csr.d_sel      = funct3[2];
      o_csr.rd_csr_en  = csr_op;
      if (op26 && !op20) begin
         o_csr.addr = CSR_MSCRATCH;
      end else if (op26 && !op21) begin
         o_csr.addr = CSR_MEPC;
      end else if (op26) begin
         o_csr.addr = CSR_MTVAL;
      end else begin
         o_csr.addr = CSR_MTVEC;
      end
   end

   // Jumps always, branches when the compare disagrees with funct3[0]
   assign o_take_branch = opcode[4] & ~opcode[2] & (opcode[0] | (i_cmp ^ funct3[0]));
   assign o_imm         = imm_q[0];

endmodule

// File: hdl/decode_top.sv
`timescale 1ns/1ps

module decode_top
   import decode_pkg::*;
(
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_wb_en,
   input  logic [XLEN-1:0] i_wb_rdt,
   input  logic            i_start,
   input  logic            i_rs1_bit,
   input  logic            i_rs2_bit,
   output flow_ctrl_t      o_flow,
   output alu_ctrl_t       o_alu,
   output mem_ctrl_t       o_mem,
   output rf_ctrl_t        o_rf,
   output csr_ctrl_t       o_csr,
   output logic            o_imm,
   output logic            o_cnt_active,
   output logic            o_done,
   output logic            o_take_branch
);

   logic cnt_en;
   logic cnt_last;
   logic cmp_result;

   count_sequencer i_count_sequencer (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_start    (i_start),
      .o_cnt_en   (cnt_en),
      .o_cnt_last (cnt_last),
      .o_done     (o_done)
   );

   // Compare mode comes from the decoded branch funct3
   serial_compare i_serial_compare (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_cnt_en   (cnt_en),
      .i_cnt_last (cnt_last),
      .i_rs1_bit  (i_rs1_bit),
      .i_rs2_bit  (i_rs2_bit),
      .i_alu      (o_alu),
      .o_cmp      (cmp_result)
   );

   instr_decoder i_instr_decoder (
      .clk           (clk),
      .i_wb_en       (i_wb_en),
      .i_cnt_en      (cnt_en),
      .i_cmp         (cmp_result),
      .i_wb_rdt      (i_wb_rdt),
      .o_flow        (o_flow),
      .o_alu         (o_alu),
      .o_mem         (o_mem),
      .o_rf          (o_rf),
      .o_csr         (o_csr),
      .o_take_branch (o_take_branch),
      .o_imm         (o_imm)
   );

   assign o_cnt_active = cnt_en;

endmodule

// File: verification/tb_decode_top.sv
`timescale 1ns/1ps

module tb_decode_top
   import decode_pkg::*;
();

   logic            clk;
   logic            i_rst;
   logic            i_wb_en;
   logic [XLEN-1:0] i_wb_rdt;
   logic            i_start;
   logic            i_rs1_bit;
   logic            i_rs2_bit;
   flow_ctrl_t      o_flow;
   alu_ctrl_t       o_alu;
   mem_ctrl_t       o_mem;
   rf_ctrl_t        o_rf;
   csr_ctrl_t       o_csr;
   logic            o_imm;
   logic            o_cnt_active;
   logic            o_done;
   logic            o_take_branch;

   int          pass_count;
   int          fail_count;
   logic [31:0] lfsr_state;

   decode_top i_decode_top (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_wb_en       (i_wb_en),
      .i_wb_rdt      (i_wb_rdt),
      .i_start       (i_start),
      .i_rs1_bit     (i_rs1_bit),
      .i_rs2_bit     (i_rs2_bit),
      .o_flow        (o_flow),
      .o_alu         (o_alu),
      .o_mem         (o_mem),
      .o_rf          (o_rf),
      .o_csr         (o_csr),
      .o_imm         (o_imm),
      .o_cnt_active  (o_cnt_active),
      .o_done        (o_done),
      .o_take_branch (o_take_branch)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   // One LFSR step per bit taken
   task automatic random_word(output logic [31:0] w);
      for (int k = 0; k < 32; k++) begin
         w[k]       = lfsr_state[0];
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // RV32I instruction encoders
   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, OP_OP, 2'b11};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] op);
      return {imm, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE, 2'b11};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH, 2'b11};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL, 2'b11};
   endfunction

   // Reference decode
   function automatic rf_ctrl_t rf_ref(input logic [31:0] instr);
      rf_ctrl_t e;
      e.rd_en    = !((instr[6:2] == OP_STORE) || (instr[6:2] == OP_BRANCH));
      e.rd_addr  = instr[11:7];
      e.rs1_addr = instr[19:15];
      e.rs2_addr = instr[24:20];
      return e;
   endfunction

   function automatic alu_ctrl_t alu_ref(input logic [31:0] instr);
      alu_ctrl_t  e;
      logic [2:0] f3;
      logic       reg_op;
      f3     = instr[14:12];
      reg_op = instr[6:2] == OP_OP;
      e      = '0;
      // funct7[5] on register ops
      e.sub         = reg_op & instr[30];
      e.bool_op     = f3[1:0];
      e.shift_op    = (f3 == 3'b001) || (f3 == 3'b101);
      e.sh_right    = f3 == 3'b101;
      // Arithmetic right shift when funct7[5] is set
      e.sh_signed   = e.sh_right & instr[30];
      e.slt_op      = (f3 == 3'b010) || (f3 == 3'b011);
      e.op_b_source = reg_op;
      e.rd_alu_en   = 1'b1;
      case (f3)
         3'b000:         e.rd_sel = ALU_RESULT_ADD;
         3'b001, 3'b101: e.rd_sel = ALU_RESULT_SR;
         3'b010, 3'b011: e.rd_sel = ALU_RESULT_LT;
         default:        e.rd_sel = ALU_RESULT_BOOL;
      endcase
      return e;
   endfunction

   function automatic mem_ctrl_t mem_ref(input logic [31:0] instr);
      mem_ctrl_t e;
      logic      ld;
      logic      st;
      ld          = instr[6:2] == OP_LOAD;
      st          = instr[6:2] == OP_STORE;
      e.mem_op    = ld | st;
      e.cmd       = st;
      e.is_signed = ~instr[14];
      e.word      = instr[13:12] == 2'b10;
      e.half      = instr[13:12] == 2'b01;
      // Memory result select for loads and stores
      e.rd_mem_en = ld | st;
      return e;
   endfunction

   function automatic csr_ctrl_t csr_ref(input logic [31:0] instr);
      csr_ctrl_t e;
      e           = '0;
      e.source    = instr[13:12];
      e.d_sel     = instr[14];
      e.rd_csr_en = 1'b1;
      case (instr[31:20])
         12'h340: begin
            e.en   = 1'b1;
            e.addr = CSR_MSCRATCH;
         end
         12'h341: begin
            e.en   = 1'b1;
            e.addr = CSR_MEPC;
         end
         12'h343: begin
            e.en   = 1'b1;
            e.addr = CSR_MTVAL;
         end
         12'h305: begin
            e.en   = 1'b1;
            e.addr = CSR_MTVEC;
         end
         12'h300: e.mstatus_en = 1'b1;
         12'h304: e.mie_en = 1'b1;
         default: e.mcause_en = 1'b1;
      endcase
      return e;
   endfunction

   // Flow flags of ecall, ebreak and mret
   function automatic flow_ctrl_t flow_ref(input logic [31:0] instr);
      flow_ctrl_t e;
      e        = '0;
      e.e_op   = (instr == 32'h0000_0073) || (instr == 32'h0010_0073);
      e.ebreak = instr == 32'h0010_0073;
      e.mret   = instr == 32'h3020_0073;
      return e;
   endfunction

   function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic check_word(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
      if (exp !== act) begin
         fail_count++;
         $display("CHECK FAILED time %0t: %s expected %h actual %h", $time, name, exp, act);
      end else begin
         pass_count++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      check_word(name, {31'd0, exp}, {31'd0, act});
   endtask

   task automatic check_flow(input string name, input flow_ctrl_t exp, input flow_ctrl_t act);
      check_word(name, 32'(exp), 32'(act));
   endtask

   task automatic check_alu(input string name, input alu_ctrl_t exp, input alu_ctrl_t act);
      alu_ctrl_t e;
      alu_ctrl_t a;
      e = exp;
      a = act;
      // Compare mode belongs to branches
      {e.cmp_eq, e.cmp_uns} = 2'b00;
      {a.cmp_eq, a.cmp_uns} = 2'b00;
      // Shift direction and sign only mean something on shifts
      if (!exp.shift_op) begin
         {e.sh_signed, e.sh_right} = 2'b00;
         {a.sh_signed, a.sh_right} = 2'b00;
      end
      check_word(name, 32'(e), 32'(a));
   endtask

   task automatic check_mem(input string name, input mem_ctrl_t exp, input mem_ctrl_t act);
      check_word(name, 32'(exp), 32'(act));
   endtask

   task automatic check_rf(input string name, input rf_ctrl_t exp, input rf_ctrl_t act);
      check_word(name, 32'(exp), 32'(act));
   endtask

   task automatic check_csr(input string name, input csr_ctrl_t exp, input csr_ctrl_t act);
      csr_ctrl_t e;
      csr_ctrl_t a;
      e = exp;
      a = act;
      // No stored CSR selected, so addr is free
      if (!exp.en) begin
         e.addr = CSR_MSCRATCH;
         a.addr = CSR_MSCRATCH;
      end
      check_word(name, 32'(e), 32'(a));
   endtask

   // Strobe one word, then wait until rd_sel has settled
   task automatic write_instr(input logic [31:0] instr);
      i_wb_rdt = instr;
      i_wb_en  = 1'b1;
      @(posedge clk);
      #1;
      i_wb_en = 1'b0;
      @(posedge clk);
      #1;
   endtask

   // Feeds operand bits and gathers immediate bits until done
   task automatic run_pass(input logic [31:0] a, input logic [31:0] b,
                           output logic [31:0] bits, output int active,
                           output logic taken);
      logic seen_done;
      seen_done = 1'b0;
      bits      = '0;
      active    = 0;
      taken     = 1'bx;
      i_start   = 1'b1;
      for (int cyc = 0; cyc < 100 && !seen_done; cyc++) begin
         @(posedge clk);
         #1;
         i_start = 1'b0;
         if (o_done) begin
            seen_done = 1'b1;
            taken     = o_take_branch;
         end else if (o_cnt_active) begin
            bits[active[4:0]] = o_imm;
            i_rs1_bit         = a[active[4:0]];
            i_rs2_bit         = b[active[4:0]];
            active++;
         end
      end
      if (!seen_done) begin
         fail_count++;
         $display("Timed out after 100 cycles waiting for o_done");
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      $display("%s finished with %0d failed checks", name, fail_count - errs_before);
   endtask

   task automatic test_reset();
      int errs;
      errs = fail_count;
      for (int k = 0; k < 5; k++) begin
         @(posedge clk);
         #1;
         check_bit("o_cnt_active", 1'b0, o_cnt_active);
         check_bit("o_done", 1'b0, o_done);
      end
      end_test("reset state", errs);
   endtask

   task automatic test_alu();
      logic [31:0] instr [8];
      int          errs;
      errs     = fail_count;
      instr[0] = enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd1);
      instr[1] = enc_r(7'h20, 5'd31, 5'd17, 3'b000, 5'd9);
      instr[2] = enc_r(7'h00, 5'd12, 5'd4, 3'b010, 5'd30);
      instr[3] = enc_r(7'h00, 5'd6, 5'd8, 3'b011, 5'd7);
      instr[4] = enc_r(7'h00, 5'd21, 5'd10, 3'b001, 5'd11);
      instr[5] = enc_r(7'h20, 5'd1, 5'd29, 3'b101, 5'd15);
      instr[6] = enc_r(7'h00, 5'd18, 5'd19, 3'b100, 5'd20);
      // addi with imm bit 10 set
      instr[7] = enc_i(12'h4d3, 5'd5, 3'b000, 5'd26, OP_OPIMM);
      foreach (instr[n]) begin
         write_instr(instr[n]);
         check_rf($sformatf("o_rf for %h", instr[n]), rf_ref(instr[n]), o_rf);
         check_alu($sformatf("o_alu for %h", instr[n]), alu_ref(instr[n]), o_alu);
      end
      end_test("alu and register fields", errs);
   endtask

   task automatic test_imm();
      logic [31:0] instr [5];
      logic [31:0] exp [5];
      logic [31:0] bits;
      logic        taken;
      int          active;
      int          errs;
      errs     = fail_count;
      instr[0] = enc_i(12'h7a5, 5'd9, 3'b000, 5'd4, OP_OPIMM);
      exp[0]   = 32'h0000_07a5;
      instr[1] = enc_s(12'h96c, 5'd7, 5'd8, 3'b010);
      exp[1]   = 32'hffff_f96c;
      instr[2] = enc_b(13'h1b56, 5'd3, 5'd14, 3'b001);
      exp[2]   = 32'hffff_fb56;
      instr[3] = {20'h8badc, 5'd2, OP_LUI, 2'b11};
      exp[3]   = 32'h8bad_c000;
      instr[4] = enc_j(21'h1d2468, 5'd1);
      exp[4]   = 32'hfffd_2468;
      foreach (instr[n]) begin
         write_instr(instr[n]);
         run_pass(32'h0, 32'h0, bits, active, taken);
         check_word($sformatf("o_imm for %h", instr[n]), exp[n], bits);
         check_word("o_cnt_active cycles", 32'd32, active);
      end
      end_test("immediates", errs);
   endtask

   task automatic test_branch();
      logic [31:0] a [3];
      logic [31:0] b [3];
      logic [2:0]  f3s [6];
      logic [31:0] bits;
      logic        taken;
      int          active;
      int          errs;
      errs = fail_count;
      random_word(a[0]);
      random_word(b[0]);
      random_word(a[1]);
      b[1] = a[1];
      // Operands that differ in the sign bit only
      random_word(a[2]);
      b[2] = a[2] ^ 32'h8000_0000;
      f3s  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
      for (int p = 0; p < 3; p++) begin
         foreach (f3s[n]) begin
            write_instr(enc_b(13'h0ff0, 5'd11, 5'd12, f3s[n]));
            run_pass(a[p], b[p], bits, active, taken);
            check_bit($sformatf("o_take_branch f3 %b a %h b %h", f3s[n], a[p], b[p]),
                      branch_ref(f3s[n], a[p], b[p]), taken);
         end
      end
      write_instr(enc_j(21'h000800, 5'd1));
      run_pass(a[0], b[0], bits, active, taken);
      check_bit("o_take_branch for jal", 1'b1, taken);
      end_test("branch decisions", errs);
   endtask

   task automatic test_mem();
      logic [31:0] instr [5];
      int          errs;
      errs     = fail_count;
      instr[0] = enc_i(12'h010, 5'd2, 3'b000, 5'd10, OP_LOAD);
      instr[1] = enc_i(12'h7fe, 5'd3, 3'b101, 5'd12, OP_LOAD);
      instr[2] = enc_i(12'hffc, 5'd4, 3'b010, 5'd13, OP_LOAD);
      instr[3] = enc_s(12'h7f0, 5'd5, 5'd6, 3'b000);
      instr[4] = enc_s(12'h804, 5'd7, 5'd8, 3'b010);
      foreach (instr[n]) begin
         write_instr(instr[n]);
         check_mem($sformatf("o_mem for %h", instr[n]), mem_ref(instr[n]), o_mem);
         check_rf($sformatf("o_rf for %h", instr[n]), rf_ref(instr[n]), o_rf);
      end
      end_test("loads and stores", errs);
   endtask

   task automatic test_system();
      logic [11:0] csr [7];
      logic [31:0] priv [3];
      logic [31:0] instr;
      int          errs;
      errs = fail_count;
      csr  = '{12'h340, 12'h341, 12'h305, 12'h343, 12'h300, 12'h304, 12'h342};
      priv = '{32'h0000_0073, 32'h0010_0073, 32'h3020_0073};
      foreach (csr[n]) begin
         // csrrw for the stored CSRs, csrrs for the rest
         instr = enc_i(csr[n], 5'd9, (n < 4) ? 3'b001 : 3'b010, 5'd10, OP_SYSTEM);
         write_instr(instr);
         check_csr($sformatf("o_csr for %h", instr), csr_ref(instr), o_csr);
      end
      foreach (priv[n]) begin
         write_instr(priv[n]);
         check_flow($sformatf("o_flow for %h", priv[n]), flow_ref(priv[n]), o_flow);
      end
      end_test("csr and system", errs);
   endtask

   initial begin
      pass_count = 0;
      fail_count = 0;
      lfsr_state = 32'hd764854a;
      i_rst      = 1'b1;
      i_wb_en    = 1'b0;
      i_wb_rdt   = '0;
      i_start    = 1'b0;
      i_rs1_bit  = 1'b0;
      i_rs2_bit  = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      i_rst = 1'b0;
      test_reset();
      test_alu();
      test_imm();
      test_branch();
      test_mem();
      test_system();
      $display("Checks passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: flist.f
hdl/decode_pkg.sv
hdl/count_sequencer.sv
hdl/serial_compare.sv
hdl/instr_decoder.sv
hdl/decode_top.sv
verification/tb_decode_top.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_decode_top
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Status comes from the search for the pass line in the simulator output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
